//--- verilog/periph_macros.svh
// ------------------------------------------------
// Address map and sizing for the peripheral block
// Include wherever region bases, register offsets
// or channel and source counts are needed
// ------------------------------------------------
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Bus widths
`define PERIPH_ADDR_WIDTH  12
`define PERIPH_DATA_WIDTH  32

// Region bases, one 256 byte region each, decoded on bits 11:8
`define PERIPH_TIMER_BASE  12'h000
`define PERIPH_PLIC_BASE   12'h100

`define PERIPH_NUM_TIMERS  2
`define PERIPH_NUM_SOURCES 4
`define PERIPH_PRIO_WIDTH  3

// Timer offsets inside one channel, channel stride 0x10
`define TMR_CTRL           4'h0
`define TMR_COUNT          4'h4
`define TMR_CMP            4'h8
`define TMR_STATUS         4'hC

// Interrupt controller offsets, source n priority at PLIC_PRIO + 4n
`define PLIC_PRIO          8'h00
`define PLIC_PENDING       8'h40
`define PLIC_ENABLE        8'h44
`define PLIC_THRESHOLD     8'h48
`define PLIC_CLAIM         8'h4C

`endif

//--- verilog/periph_bus_pkg.sv
// ------------------------------------------------
// Bus side types shared by the decoder and the
// register mapped devices
// ------------------------------------------------
`include "periph_macros.svh"

package periph_bus_pkg;

    // Wishbone byte address
    typedef logic [`PERIPH_ADDR_WIDTH-1:0] addr_t;

    // Register and bus data word
    typedef logic [`PERIPH_DATA_WIDTH-1:0] data_t;

    // Decoded device region
    typedef enum logic [1:0] {
        REGION_TIMER,
        REGION_PLIC,
        REGION_NONE
    } region_e;

endpackage

//--- verilog/periph_irq_pkg.sv
// ------------------------------------------------
// Interrupt side types for the source vector, ids,
// priorities and the gateway state machine
// ------------------------------------------------
`include "periph_macros.svh"

package periph_irq_pkg;

    // One bit per source, bit n-1 holds source n
    typedef logic [`PERIPH_NUM_SOURCES-1:0] src_vec_t;

    // Source id, 0 means no interrupt
    typedef logic [$clog2(`PERIPH_NUM_SOURCES+1)-1:0] src_id_t;

    // Priority or threshold
    typedef logic [`PERIPH_PRIO_WIDTH-1:0] prio_t;

    typedef enum logic [1:0] {
        GW_IDLE,
        GW_PENDING,
        GW_IN_SERVICE
    } gw_state_e;

endpackage

//--- verilog/periph_decoder.sv
// ------------------------------------------------
// Wishbone address decoder in front of the timer
// and interrupt controller regions
// Unmapped requests end with a one cycle error
// ------------------------------------------------
`include "periph_macros.svh"

module periph_decoder
    import periph_bus_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  addr_t wb_adr_i,
    input  logic  tmr_ack_i,
    input  logic  plic_ack_i,
    input  data_t tmr_dat_i,
    input  data_t plic_dat_i,
    output logic  tmr_stb_o,
    output logic  plic_stb_o,
    output data_t wb_dat_o,
    output logic  wb_ack_o,
    output logic  wb_err_o
);

    localparam addr_t TMR_BASE  = `PERIPH_TIMER_BASE;
    localparam addr_t PLIC_BASE = `PERIPH_PLIC_BASE;

    logic    req;
    region_e region;
    logic    err_q;

    assign req = wb_cyc_i & wb_stb_i;

    // Region from the upper address nibble
    always_comb begin
        if (wb_adr_i[11:8] == TMR_BASE[11:8]) begin
            region = REGION_TIMER;
        end else if (wb_adr_i[11:8] == PLIC_BASE[11:8]) begin
            region = REGION_PLIC;
        end else begin
            region = REGION_NONE;
        end
    end

    assign tmr_stb_o  = req & (region == REGION_TIMER);
    assign plic_stb_o = req & (region == REGION_PLIC);

    // Error answer for holes in the map, one pulse per request
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & (region == REGION_NONE) & ~err_q;
        end
    end

    // Response mux, address is held until the response is seen
    always_comb begin
        case (region)
            REGION_TIMER: begin
                wb_ack_o = tmr_ack_i;
                wb_dat_o = tmr_dat_i;
            end
            REGION_PLIC: begin
                wb_ack_o = plic_ack_i;
                wb_dat_o = plic_dat_i;
            end
            default: begin
                wb_ack_o = 1'b0;
                wb_dat_o = '0;
            end
        endcase
    end

    assign wb_err_o = err_q;

endmodule

//--- verilog/periph_timer.sv
// ------------------------------------------------
// Compare timers with a register port
// Each channel counts up while enabled, wraps on a
// compare match and sets a sticky status bit
// ------------------------------------------------
`include "periph_macros.svh"

module periph_timer
    import periph_bus_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          stb_i,
    input  logic                          we_i,
    input  addr_t                         adr_i,
    input  data_t                         dat_i,
    output data_t                         dat_o,
    output logic                          ack_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] irq_o
);

    logic [`PERIPH_NUM_TIMERS-1:0] tmr_en;
    data_t                         tmr_cnt [`PERIPH_NUM_TIMERS];
    data_t                         tmr_cmp [`PERIPH_NUM_TIMERS];
    logic [`PERIPH_NUM_TIMERS-1:0] tmr_status;

    logic  ack_q;
    data_t dat_q;
    logic  wr_en;
    logic  rd_en;
    data_t rd_data;

    // Only the first cycle of a request has side effects
    assign wr_en = stb_i & we_i & ~ack_q;
    assign rd_en = stb_i & ~we_i & ~ack_q;

    always_comb begin
        rd_data = '0;
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            if (adr_i[7:4] == 4'(i)) begin
                case (adr_i[3:0])
                    `TMR_CTRL:   rd_data = data_t'(tmr_en[i]);
                    `TMR_COUNT:  rd_data = tmr_cnt[i];
                    `TMR_CMP:    rd_data = tmr_cmp[i];
                    `TMR_STATUS: rd_data = data_t'(tmr_status[i]);
                    default:     rd_data = '0;
                endcase
            end
        end
    end

    // ------------------------------------------------
    // Channel registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tmr_en     <= '0;
            tmr_status <= '0;
            for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
                tmr_cnt[i] <= '0;
                tmr_cmp[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
                // Free count, back to zero the cycle after a match
                if (tmr_en[i]) begin
                    if (tmr_cnt[i] == tmr_cmp[i]) begin
                        tmr_cnt[i] <= '0;
                    end else begin
                        tmr_cnt[i] <= tmr_cnt[i] + 1'b1;
                    end
                end
                if (wr_en && adr_i[7:4] == 4'(i)) begin
                    case (adr_i[3:0])
                        `TMR_CTRL:   tmr_en[i]  <= dat_i[0];
                        `TMR_COUNT:  tmr_cnt[i] <= dat_i;
                        `TMR_CMP:    tmr_cmp[i] <= dat_i;
                        `TMR_STATUS: begin
                            if (dat_i[0]) begin
                                tmr_status[i] <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
                // A match in the same cycle as a clear wins
                if (tmr_en[i] && tmr_cnt[i] == tmr_cmp[i]) begin
                    tmr_status[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= stb_i & ~ack_q;
            if (rd_en) begin
                dat_q <= rd_data;
            end
        end
    end

    assign ack_o = ack_q;
    assign dat_o = dat_q;
    assign irq_o = tmr_status;

endmodule

//--- verilog/periph_plic.sv
// ------------------------------------------------
// Level triggered interrupt controller, one target
// Per source gateway, priority and enable, a global
// threshold and the claim/complete register
// ------------------------------------------------
`include "periph_macros.svh"

module periph_plic
    import periph_bus_pkg::*;
    import periph_irq_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  addr_t    adr_i,
    input  data_t    dat_i,
    input  src_vec_t src_i,
    output data_t    dat_o,
    output logic     ack_o,
    output logic     irq_o
);

    gw_state_e gw_q   [`PERIPH_NUM_SOURCES];
    prio_t     prio_q [`PERIPH_NUM_SOURCES];
    src_vec_t  en_q;
    prio_t     thr_q;
    src_vec_t  pend_vec;

    src_id_t best_id;
    prio_t   best_prio;

    logic  ack_q;
    data_t dat_q;
    logic  irq_q;
    logic  wr_en;
    logic  rd_en;
    logic  claim;
    logic  complete;
    data_t rd_data;

    assign wr_en    = stb_i & we_i & ~ack_q;
    assign rd_en    = stb_i & ~we_i & ~ack_q;
    assign claim    = rd_en & (adr_i[7:0] == `PLIC_CLAIM);
    assign complete = wr_en & (adr_i[7:0] == `PLIC_CLAIM);

    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
            pend_vec[i] = (gw_q[i] == GW_PENDING);
        end
    end

    // Highest priority above threshold, strict compare keeps the lowest id on ties
    always_comb begin
        best_id   = '0;
        best_prio = thr_q;
        for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
            if (pend_vec[i] && en_q[i] && prio_q[i] > best_prio) begin
                best_id   = src_id_t'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (adr_i[7:0])
            `PLIC_PENDING:   rd_data = data_t'(pend_vec);
            `PLIC_ENABLE:    rd_data = data_t'(en_q);
            `PLIC_THRESHOLD: rd_data = data_t'(thr_q);
            `PLIC_CLAIM:     rd_data = data_t'(best_id);
            default: begin
                for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
                    if (adr_i[7:0] == `PLIC_PRIO + 8'(4 * (i + 1))) begin
                        rd_data = data_t'(prio_q[i]);
                    end
                end
            end
        endcase
    end

    // ------------------------------------------------
    // Gateways and configuration registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q  <= '0;
            thr_q <= '0;
            for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
                gw_q[i]   <= GW_IDLE;
                prio_q[i] <= '0;
            end
        end else begin
            if (wr_en && adr_i[7:0] == `PLIC_ENABLE) begin
                en_q <= dat_i[`PERIPH_NUM_SOURCES-1:0];
            end
            if (wr_en && adr_i[7:0] == `PLIC_THRESHOLD) begin
                thr_q <= dat_i[`PERIPH_PRIO_WIDTH-1:0];
            end
            for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
                if (wr_en && adr_i[7:0] == `PLIC_PRIO + 8'(4 * (i + 1))) begin
                    prio_q[i] <= dat_i[`PERIPH_PRIO_WIDTH-1:0];
                end
                case (gw_q[i])
                    GW_IDLE: begin
                        if (src_i[i]) begin
                            gw_q[i] <= GW_PENDING;
                        end
                    end
                    GW_PENDING: begin
                        if (claim && best_id == src_id_t'(i + 1)) begin
                            gw_q[i] <= GW_IN_SERVICE;
                        end
                    end
                    GW_IN_SERVICE: begin
                        // Source stays masked until its id is completed
                        if (complete && dat_i[$bits(src_id_t)-1:0] == src_id_t'(i + 1)) begin
                            gw_q[i] <= GW_IDLE;
                        end
                    end
                    default: gw_q[i] <= GW_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
            irq_q <= 1'b0;
        end else begin
            ack_q <= stb_i & ~ack_q;
            irq_q <= (best_id != '0);
            if (rd_en) begin
                dat_q <= rd_data;
            end
        end
    end

    assign ack_o = ack_q;
    assign dat_o = dat_q;
    assign irq_o = irq_q;

endmodule

//--- verilog/periph_top.sv
// ------------------------------------------------
// Peripheral block top, one Wishbone slave port in
// front of the timer and interrupt controller
// ------------------------------------------------
`include "periph_macros.svh"

module periph_top
    import periph_bus_pkg::*;
    import periph_irq_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  addr_t      wb_adr_i,
    input  data_t      wb_dat_i,
    output data_t      wb_dat_o,
    output logic       wb_ack_o,
    output logic       wb_err_o,
    input  logic [1:0] ext_irq_i,
    output logic       irq_o
);

    logic                          tmr_stb;
    logic                          plic_stb;
    logic                          tmr_ack;
    logic                          plic_ack;
    data_t                         tmr_dat;
    data_t                         plic_dat;
    logic [`PERIPH_NUM_TIMERS-1:0] tmr_irq;
    src_vec_t                      src_vec;

    // Sources 1 and 2 are the timers, 3 and 4 the external lines
    assign src_vec = {ext_irq_i, tmr_irq};

    periph_decoder i_decoder (
        .clk_i      ( clk_i    ),
        .arst_n_i   ( arst_n_i ),
        .wb_cyc_i   ( wb_cyc_i ),
        .wb_stb_i   ( wb_stb_i ),
        .wb_adr_i   ( wb_adr_i ),
        .tmr_ack_i  ( tmr_ack  ),
        .plic_ack_i ( plic_ack ),
        .tmr_dat_i  ( tmr_dat  ),
        .plic_dat_i ( plic_dat ),
        .tmr_stb_o  ( tmr_stb  ),
        .plic_stb_o ( plic_stb ),
        .wb_dat_o   ( wb_dat_o ),
        .wb_ack_o   ( wb_ack_o ),
        .wb_err_o   ( wb_err_o )
    );

    periph_timer i_timer (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .stb_i    ( tmr_stb  ),
        .we_i     ( wb_we_i  ),
        .adr_i    ( wb_adr_i ),
        .dat_i    ( wb_dat_i ),
        .dat_o    ( tmr_dat  ),
        .ack_o    ( tmr_ack  ),
        .irq_o    ( tmr_irq  )
    );

    periph_plic i_plic (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .stb_i    ( plic_stb ),
        .we_i     ( wb_we_i  ),
        .adr_i    ( wb_adr_i ),
        .dat_i    ( wb_dat_i ),
        .src_i    ( src_vec  ),
        .dat_o    ( plic_dat ),
        .ack_o    ( plic_ack ),
        .irq_o    ( irq_o    )
    );

endmodule

//--- sim/tb_periph_top.sv
// ------------------------------------------------
// Testbench for the peripheral block, replays the
// command list in sim/periph_stim.txt on the
// Wishbone port and interrupt lines
// ------------------------------------------------
module tb_periph_top;

    localparam int BUS_TIMEOUT = 16;
    localparam int MAX_LINES   = 1000;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    logic        wb_err;
    logic [1:0]  ext_irq;
    logic        irq;

    int error_count;
    int tests_run;
    int tests_failed;
    logic test_failed;

    periph_top UUT (
        .clk_i     ( clk      ),
        .arst_n_i  ( arst_n   ),
        .wb_cyc_i  ( wb_cyc   ),
        .wb_stb_i  ( wb_stb   ),
        .wb_we_i   ( wb_we    ),
        .wb_adr_i  ( wb_adr   ),
        .wb_dat_i  ( wb_wdata ),
        .wb_dat_o  ( wb_rdata ),
        .wb_ack_o  ( wb_ack   ),
        .wb_err_o  ( wb_err   ),
        .ext_irq_i ( ext_irq  ),
        .irq_o     ( irq      )
    );

    always #50 clk = ~clk;

    task automatic check_value(input logic [8*32-1:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            error_count++;
            test_failed = 1'b1;
        end
    endtask

    task automatic report_failure(input logic [8*32-1:0] name, input string msg);
        $display("%0s: %0s", name, msg);
        error_count++;
        test_failed = 1'b1;
    endtask

    // One Wishbone classic cycle that drops stb once the response is seen
    task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic got_ack,
                              output logic got_err, output logic timed_out);
        int   cycles;
        logic seen;
        seen    = 1'b0;
        cycles  = 0;
        rdata   = '0;
        got_ack = 1'b0;
        got_err = 1'b0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        while (!seen && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (wb_ack || wb_err) begin
                seen    = 1'b1;
                got_ack = wb_ack;
                got_err = wb_err;
                rdata   = wb_rdata;
            end
        end
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        timed_out = !seen;
    endtask

    task automatic wait_for_irq(input logic [31:0] limit, output logic timed_out);
        logic [31:0] cycles;
        logic        seen;
        cycles = '0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 32'd1;
            seen   = irq;
        end
        timed_out = !seen;
    endtask

    task automatic irq_stays_low(input logic [8*32-1:0] name, input logic [31:0] limit);
        logic [31:0] cycles;
        logic        high;
        cycles = '0;
        high   = 1'b0;
        while (!high && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 32'd1;
            high   = irq;
        end
        check_value(name, 32'd0, 32'(high));
    endtask

    task automatic run_command(input logic [15:0] op, input logic [31:0] adr,
                               input logic [31:0] data, input logic [31:0] expect_val,
                               input logic [8*32-1:0] name);
        logic [31:0] rdata;
        logic        got_ack;
        logic        got_err;
        logic        timed_out;
        if (op == "WR" || op == "RD" || op == "EW" || op == "ER") begin
            bus_access(op == "WR" || op == "EW", adr[11:0], data, rdata, got_ack, got_err,
                       timed_out);
            if (timed_out) begin
                report_failure(name, "no ack or err came back from the bus");
            end else if (op == "WR" || op == "RD") begin
                check_value(name, 32'd1, 32'(got_ack));
                check_value(name, 32'd0, 32'(got_err));
                if (op == "RD") begin
                    check_value(name, expect_val, rdata);
                end
            end else begin
                // Holes in the map answer with err and zero data
                check_value(name, 32'd0, 32'(got_ack));
                check_value(name, 32'd1, 32'(got_err));
                check_value(name, 32'd0, rdata);
            end
        end else if (op == "EX") begin
            @(negedge clk);
            ext_irq = data[1:0];
        end else if (op == "WI") begin
            wait_for_irq(data, timed_out);
            if (timed_out) begin
                report_failure(name, "irq_o did not rise before the timeout");
            end
        end else if (op == "LO") begin
            irq_stays_low(name, data);
        end else begin
            report_failure(name, "unknown operation in the stimulus file");
        end
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $urandom % 4;
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int              fd;
        int              n;
        int              code;
        int              lines;
        logic            done;
        logic [15:0]     op;
        logic [31:0]     adr;
        logic [31:0]     data;
        logic [31:0]     expect_val;
        logic [8*32-1:0] name;
        logic [8*200-1:0] skip_line;

        clk          = 1'b0;
        arst_n       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_wdata     = '0;
        ext_irq      = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_failed  = 1'b0;
        void'($urandom(48912));

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        fd = $fopen("sim/periph_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/periph_stim.txt");
            error_count++;
        end else begin
            done  = 1'b0;
            lines = 0;
            while (!done && lines < MAX_LINES) begin
                lines++;
                n = $fscanf(fd, "%s", op);
                if (n != 1) begin
                    done = 1'b1;
                end else if (op[7:0] == "#") begin
                    code = $fgets(skip_line, fd);
                    if (code == 0) begin
                        done = 1'b1;
                    end
                end else begin
                    n = $fscanf(fd, "%h %h %h %s", adr, data, expect_val, name);
                    if (n != 4) begin
                        $display("Stimulus line %0d is malformed", lines);
                        error_count++;
                        done = 1'b1;
                    end else begin
                        test_failed = 1'b0;
                        run_command(op, adr, data, expect_val, name);
                        tests_run++;
                        if (test_failed) begin
                            tests_failed++;
                            $display("test %0s: FAILED", name);
                        end else begin
                            $display("test %0s: ok", name);
                        end
                        idle_gap();
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0 && tests_run > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim/periph_stim.txt
# op addr data expect name (hex fields); WR write, RD read and compare, EW/ER access expecting err
# EX set ext irq to data, WI wait for irq_o with data as timeout, LO irq_o low for data cycles
WR 018 0000ABCD 00000000 tmr1_cmp_wr
RD 018 00000000 0000ABCD tmr1_cmp_rd
WR 108 0000000D 00000000 src2_prio_wr
RD 108 00000000 00000005 src2_prio_rd
WR 148 0000000E 00000000 thr_wr
RD 148 00000000 00000006 thr_rd
WR 144 000000F6 00000000 enable_wr
RD 144 00000000 00000006 enable_rd
ER 200 00000000 00000000 unmapped_rd
EW 208 DEADBEEF 00000000 unmapped_wr_tmr_alias
RD 008 00000000 00000000 tmr0_cmp_unchanged
EW 348 00000001 00000000 unmapped_wr_plic_alias
RD 148 00000000 00000006 thr_unchanged
ER F4C 00000000 00000000 unmapped_rd_top
WR 104 00000001 00000000 src1_prio_one
WR 148 00000000 00000000 thr_zero
WR 144 00000001 00000000 enable_src1
WR 008 00000014 00000000 tmr0_cmp_20
LO 000 00000005 00000000 irq_idle_before_tmr
WR 000 00000001 00000000 tmr0_enable
WI 000 000000C8 00000000 tmr_irq_rise
RD 14C 00000000 00000001 claim_tmr
RD 00C 00000000 00000001 tmr0_status_set
WR 000 00000000 00000000 tmr0_disable
WR 00C 00000001 00000000 tmr0_status_clr
RD 00C 00000000 00000000 tmr0_status_clr_rd
WR 14C 00000001 00000000 complete_tmr
LO 000 0000001E 00000000 irq_quiet_after_tmr
WR 10C 00000002 00000000 src3_prio_two
WR 110 00000005 00000000 src4_prio_five
WR 144 0000000C 00000000 enable_src3_src4
EX 000 00000003 00000000 ext_both_high
WI 000 00000032 00000000 prio_irq_rise
RD 140 00000000 0000000C pending_both
RD 14C 00000000 00000004 claim_prio_high
WR 10C 00000005 00000000 src3_prio_equal
RD 14C 00000000 00000003 claim_src3
RD 140 00000000 00000000 pending_none
WR 148 00000005 00000000 thr_five
WR 14C 00000004 00000000 complete_src4
LO 000 00000014 00000000 thr_mask_quiet
RD 14C 00000000 00000000 claim_masked
RD 140 00000000 00000008 pending_src4_only
WR 144 00000004 00000000 enable_src3_only
WR 148 00000000 00000000 thr_zero_again
LO 000 0000000A 00000000 src3_not_rearmed
RD 140 00000000 00000008 src3_still_serviced
WR 14C 00000003 00000000 complete_src3
WI 000 00000032 00000000 rearm_irq_rise
RD 14C 00000000 00000003 claim_rearm
EX 000 00000000 00000000 ext_low
WR 14C 00000003 00000000 complete_rearm

//--- sim.f
+incdir+verilog
verilog/periph_bus_pkg.sv
verilog/periph_irq_pkg.sv
verilog/periph_decoder.sv
verilog/periph_timer.sv
verilog/periph_plic.sv
verilog/periph_top.sv
sim/tb_periph_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the peripheral testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
BIN=tb_periph_top

verilator --binary --timing --top-module tb_periph_top -f sim.f \
    --Mdir "$OBJ_DIR" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
